// File: gpio_subsys.f
+incdir+include
logic/gpio_axil_pkg.sv
logic/gpio_map_pkg.sv
logic/gpio_reg_if.sv
logic/gpio_axil_slave.sv
logic/gpio_in_sync.sv
logic/gpio_reg_bank.sv
logic/gpio_top.sv
bench/tb_gpio_top.sv

// File: Bender.yml
package:
  name: gpio_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/gpio_axil_pkg.sv
      - logic/gpio_map_pkg.sv
      - logic/gpio_reg_if.sv
      - logic/gpio_axil_slave.sv
      - logic/gpio_in_sync.sv
      - logic/gpio_reg_bank.sv
      - logic/gpio_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_gpio_top.sv

// File: bench/tb_gpio_top.sv
`timescale 1ns/1ps

`include "gpio_cfg.svh"

module tb_gpio_top;

  localparam int DRIVE_DLY   = 1;
  localparam int BUS_TIMEOUT = 20;
  localparam int RUN_LIMIT   = 20000;
  // input change to EDGE capture, plus margin
  localparam int SETTLE      = `GPIO_SYNC_STAGES + 4;

  localparam logic [1:0]  RESP_OKAY    = 2'b00;
  localparam logic [1:0]  RESP_SLVERR  = 2'b10;
  localparam logic [31:0] CTRL_WR_MASK = 32'h0000_0F1F;
  localparam logic [31:0] OFS_CTRL     = `GPIO_OFS_CTRL;
  localparam logic [31:0] OFS_IN       = `GPIO_OFS_IN;
  localparam logic [31:0] OFS_EDGE     = `GPIO_OFS_EDGE;
  localparam logic [31:0] OFS_MASK     = `GPIO_OFS_MASK;

  logic                    sys_clk;
  logic                    rst;
  logic [`GPIO_DATA_W-1:0] awaddr;
  logic                    awvalid;
  logic                    awready;
  logic [`GPIO_DATA_W-1:0] wdata;
  logic                    wvalid;
  logic                    wready;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [`GPIO_DATA_W-1:0] araddr;
  logic                    arvalid;
  logic                    arready;
  logic [`GPIO_DATA_W-1:0] rdata;
  logic [1:0]              rresp;
  logic                    rvalid;
  logic                    rready;
  logic [`GPIO_IN_W-1:0]   gpio_bd;
  logic [`GPIO_LED_W-1:0]  gpio_led;
  logic                    radio_resetb;
  logic                    radio_en_agc;
  logic                    radio_sync;
  logic                    radio_enable;
  logic                    radio_txnrx;
  logic                    irq;

  // reference model of the register state
  logic [31:0]           ctrl_m = '0;
  logic [`GPIO_IN_W-1:0] in_m   = '0;
  logic [`GPIO_IN_W-1:0] edge_m = '0;
  logic [`GPIO_IN_W-1:0] mask_m = '0;

  integer seed;
  int     mismatch_errors = 0;
  int     timeout_errors  = 0;
  bit     timed_out       = 1'b0;
  bit     tests_done      = 1'b0;

  gpio_top i_dut (
    .sys_clk          (sys_clk),
    .rst_i            (rst),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready),
    .gpio_bd_i        (gpio_bd),
    .gpio_bd_o        (gpio_led),
    .ad9361_resetb_o  (radio_resetb),
    .ad9361_en_agc_o  (radio_en_agc),
    .ad9361_sync_o    (radio_sync),
    .ad9361_enable_o  (radio_enable),
    .ad9361_txnrx_o   (radio_txnrx),
    .irq_o            (irq)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  // **************************************************
  // helpers
  // **************************************************

  task automatic flag_timeout(input string what);
    $display("ERROR: timeout at %0t, the DUT never raised %s", $time, what);
    timeout_errors++;
    timed_out = 1'b1;
    // report process ends the run in this time step
    @(posedge sys_clk);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      mismatch_errors++;
    end
  endtask

  // ready and valid are sampled on the falling edge, where they are settled
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int cycles;
    resp    = 2'bxx;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    cycles  = 0;
    @(negedge sys_clk);
    while (!(awready && wready) && cycles < BUS_TIMEOUT) begin
      @(negedge sys_clk);
      cycles++;
    end
    if (!(awready && wready)) begin
      flag_timeout("awready and wready");
      return;
    end
    // taken on this rising edge
    @(posedge sys_clk);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    cycles  = 0;
    @(negedge sys_clk);
    while (!bvalid && cycles < BUS_TIMEOUT) begin
      @(negedge sys_clk);
      cycles++;
    end
    if (!bvalid) begin
      flag_timeout("bvalid");
      return;
    end
    check_value("bvalid delay after handshake", cycles, 0);
    resp = bresp;
    @(posedge sys_clk);
    #DRIVE_DLY;
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int cycles;
    data    = 'x;
    resp    = 2'bxx;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    cycles  = 0;
    @(negedge sys_clk);
    while (!arready && cycles < BUS_TIMEOUT) begin
      @(negedge sys_clk);
      cycles++;
    end
    if (!arready) begin
      flag_timeout("arready");
      return;
    end
    @(posedge sys_clk);
    #DRIVE_DLY;
    arvalid = 1'b0;
    cycles  = 0;
    @(negedge sys_clk);
    while (!rvalid && cycles < BUS_TIMEOUT) begin
      @(negedge sys_clk);
      cycles++;
    end
    if (!rvalid) begin
      flag_timeout("rvalid");
      return;
    end
    check_value("rvalid delay after handshake", cycles, 0);
    data = rdata;
    resp = rresp;
    @(posedge sys_clk);
    #DRIVE_DLY;
    rready = 1'b0;
  endtask

  task automatic expect_write(input string what, input logic [31:0] addr,
                              input logic [31:0] data, input logic [1:0] exp_resp);
    logic [1:0] resp;
    write_reg(addr, data, resp);
    check_value({what, " bresp"}, resp, exp_resp);
  endtask

  task automatic expect_read(input string what, input logic [31:0] addr,
                             input logic [31:0] exp, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    read_reg(addr, data, resp);
    check_value({what, " rresp"}, resp, exp_resp);
    check_value(what, data, exp);
  endtask

  // pins laid out like the control word
  task automatic check_pins();
    check_value("pins", {gpio_led, 3'b000, radio_resetb, radio_en_agc, radio_sync,
                         radio_enable, radio_txnrx}, ctrl_m);
    check_value("irq_o", irq, |(edge_m & mask_m));
  endtask

  task automatic check_model();
    expect_read("CTRL", OFS_CTRL, ctrl_m, RESP_OKAY);
    expect_read("IN", OFS_IN, in_m, RESP_OKAY);
    expect_read("EDGE", OFS_EDGE, edge_m, RESP_OKAY);
    expect_read("MASK", OFS_MASK, mask_m, RESP_OKAY);
    check_pins();
  endtask

  task automatic set_inputs(input logic [`GPIO_IN_W-1:0] value);
    // rising bits get captured once through the synchronizer
    edge_m  = edge_m | (value & ~in_m);
    in_m    = value;
    gpio_bd = value;
    repeat (SETTLE) @(posedge sys_clk);
    #DRIVE_DLY;
  endtask

  // **************************************************
  // test sequence
  // **************************************************

  initial begin : stimulus
    logic [31:0] value;
    logic [31:0] addr;
    seed    = 69;
    rst     = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    gpio_bd = '0;
    repeat (16) @(posedge sys_clk);
    #DRIVE_DLY;
    rst = 1'b0;

    // state right after reset
    check_value("ready and valid", {awready, wready, arready, bvalid, rvalid}, 0);
    check_model();

    // control word and pins
    repeat (20) begin
      value = $random(seed);
      expect_write("CTRL write", OFS_CTRL, value, RESP_OKAY);
      ctrl_m = value & CTRL_WR_MASK;
      check_pins();
      expect_read("CTRL", OFS_CTRL, ctrl_m, RESP_OKAY);
    end

    // stable inputs show up in IN
    repeat (10) begin
      set_inputs($random(seed));
      expect_read("IN", OFS_IN, in_m, RESP_OKAY);
    end

    // sticky capture and write one to clear
    expect_write("EDGE clear", OFS_EDGE, 32'hFF, RESP_OKAY);
    edge_m = '0;
    expect_read("EDGE", OFS_EDGE, edge_m, RESP_OKAY);
    repeat (16) begin
      set_inputs($random(seed));
      expect_read("EDGE", OFS_EDGE, edge_m, RESP_OKAY);
      value = $random(seed);
      expect_write("EDGE clear", OFS_EDGE, value, RESP_OKAY);
      edge_m = edge_m & ~value[`GPIO_IN_W-1:0];
      expect_read("EDGE", OFS_EDGE, edge_m, RESP_OKAY);
    end

    // interrupt from masked edges
    repeat (16) begin
      value = $random(seed);
      expect_write("MASK write", OFS_MASK, value, RESP_OKAY);
      mask_m = value[`GPIO_IN_W-1:0];
      check_pins();
      set_inputs($random(seed));
      check_pins();
      value = $random(seed);
      expect_write("EDGE clear", OFS_EDGE, value, RESP_OKAY);
      edge_m = edge_m & ~value[`GPIO_IN_W-1:0];
      check_pins();
    end
    check_model();

    // out of range accesses and writes to IN
    repeat (8) begin
      addr = $random(seed);
      if (addr < 32'h10) begin
        addr = addr + 32'h10;
      end
      expect_write("out of range write", addr, $random(seed), RESP_SLVERR);
      expect_read("out of range read", addr, 32'h0, RESP_SLVERR);
      expect_write("IN write", OFS_IN, $random(seed), RESP_OKAY);
      check_model();
    end

    tests_done = 1'b1;
  end

  initial begin : report
    int cycles;
    cycles = 0;
    while (!tests_done && !timed_out && cycles < RUN_LIMIT) begin
      @(posedge sys_clk or posedge timed_out or posedge tests_done);
      cycles++;
    end
    if (!tests_done && !timed_out) begin
      $display("ERROR: test sequence did not finish within %0d cycles", RUN_LIMIT);
      timeout_errors++;
    end
    $display("errors: %0d mismatches, %0d timeouts", mismatch_errors, timeout_errors);
    if (mismatch_errors == 0 && timeout_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: logic/gpio_top.sv
`timescale 1ns/1ps

`include "gpio_cfg.svh"

module gpio_top (
  // clock and reset
  input  logic                     sys_clk,
  input  logic                     rst_i,

  // axi4-lite slave
  input  logic [`GPIO_DATA_W-1:0]  s_axil_awaddr_i,
  input  logic                     s_axil_awvalid_i,
  output logic                     s_axil_awready_o,
  input  logic [`GPIO_DATA_W-1:0]  s_axil_wdata_i,
  input  logic                     s_axil_wvalid_i,
  output logic                     s_axil_wready_o,
  output logic [1:0]               s_axil_bresp_o,
  output logic                     s_axil_bvalid_o,
  input  logic                     s_axil_bready_i,
  input  logic [`GPIO_DATA_W-1:0]  s_axil_araddr_i,
  input  logic                     s_axil_arvalid_i,
  output logic                     s_axil_arready_o,
  output logic [`GPIO_DATA_W-1:0]  s_axil_rdata_o,
  output logic [1:0]               s_axil_rresp_o,
  output logic                     s_axil_rvalid_o,
  input  logic                     s_axil_rready_i,

  // board gpio
  input  logic [`GPIO_IN_W-1:0]    gpio_bd_i,
  output logic [`GPIO_LED_W-1:0]   gpio_bd_o,

  // ad9361 control pins
  output logic                     ad9361_resetb_o,
  output logic                     ad9361_en_agc_o,
  output logic                     ad9361_sync_o,
  output logic                     ad9361_enable_o,
  output logic                     ad9361_txnrx_o,

  output logic                     irq_o
);

  import gpio_map_pkg::*;

  gpio_ctrl_u            ctrl;
  logic [`GPIO_IN_W-1:0] in_sync;
  logic [`GPIO_IN_W-1:0] in_rise;

  gpio_reg_if i_reg_if ();

  // **************************************************
  // stages
  // **************************************************

  gpio_axil_slave i_axil_slave (
    .sys_clk     (sys_clk),
    .rst_i       (rst_i),
    .s_awaddr_i  (s_axil_awaddr_i),
    .s_awvalid_i (s_axil_awvalid_i),
    .s_awready_o (s_axil_awready_o),
    .s_wdata_i   (s_axil_wdata_i),
    .s_wvalid_i  (s_axil_wvalid_i),
    .s_wready_o  (s_axil_wready_o),
    .s_bresp_o   (s_axil_bresp_o),
    .s_bvalid_o  (s_axil_bvalid_o),
    .s_bready_i  (s_axil_bready_i),
    .s_araddr_i  (s_axil_araddr_i),
    .s_arvalid_i (s_axil_arvalid_i),
    .s_arready_o (s_axil_arready_o),
    .s_rdata_o   (s_axil_rdata_o),
    .s_rresp_o   (s_axil_rresp_o),
    .s_rvalid_o  (s_axil_rvalid_o),
    .s_rready_i  (s_axil_rready_i),
    .reg_o       (i_reg_if.master)
  );

  gpio_in_sync i_in_sync (
    .sys_clk   (sys_clk),
    .rst_i     (rst_i),
    .gpio_bd_i (gpio_bd_i),
    .in_sync_o (in_sync),
    .in_rise_o (in_rise)
  );

  gpio_reg_bank i_reg_bank (
    .sys_clk   (sys_clk),
    .rst_i     (rst_i),
    .in_sync_i (in_sync),
    .in_rise_i (in_rise),
    .reg_i     (i_reg_if.slave),
    .ctrl_o    (ctrl),
    .irq_o     (irq_o)
  );

  // control word onto the pins
  assign gpio_bd_o       = ctrl.fields.board_led;
  assign ad9361_resetb_o = ctrl.fields.radio_resetb;
  assign ad9361_en_agc_o = ctrl.fields.radio_en_agc;
  assign ad9361_sync_o   = ctrl.fields.radio_sync;
  assign ad9361_enable_o = ctrl.fields.radio_enable;
  assign ad9361_txnrx_o  = ctrl.fields.radio_txnrx;

endmodule

// File: logic/gpio_reg_bank.sv
`timescale 1ns/1ps

`include "gpio_cfg.svh"

module gpio_reg_bank (
  input  logic                     sys_clk,
  input  logic                     rst_i,
  input  logic [`GPIO_IN_W-1:0]    in_sync_i,
  input  logic [`GPIO_IN_W-1:0]    in_rise_i,
  gpio_reg_if.slave                reg_i,
  output gpio_map_pkg::gpio_ctrl_u ctrl_o,
  output logic                     irq_o
);

  import gpio_axil_pkg::*;
  import gpio_map_pkg::*;

  gpio_ctrl_u              ctrl_q;
  logic [`GPIO_IN_W-1:0]   in_q;
  logic [`GPIO_IN_W-1:0]   edge_q;
  logic [`GPIO_IN_W-1:0]   mask_q;
  logic [`GPIO_IN_W-1:0]   edge_clr;
  logic                    wr_ok;
  logic [`GPIO_DATA_W-1:0] rd_word;
  logic [`GPIO_DATA_W-1:0] rdata_q;
  axil_resp_e              resp_q;

  // out of range writes are dropped
  assign wr_ok = reg_i.wr_en && !reg_i.addr_err;

  // write one to clear
  assign edge_clr = (wr_ok && reg_i.addr == REG_EDGE) ? reg_i.wdata[`GPIO_IN_W-1:0] : '0;

  // **************************************************
  // registers
  // **************************************************

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ctrl_q.raw <= '0;
      in_q       <= '0;
      edge_q     <= '0;
      mask_q     <= '0;
    end else begin
      in_q <= in_sync_i;
      if (wr_ok && reg_i.addr == REG_CTRL) begin
        ctrl_q.raw <= reg_i.wdata & GPIO_CTRL_MASK;
      end
      if (wr_ok && reg_i.addr == REG_MASK) begin
        mask_q <= reg_i.wdata[`GPIO_IN_W-1:0];
      end
      // set after clear, so a capture in the same cycle wins
      edge_q <= (edge_q & ~edge_clr) | in_rise_i;
    end
  end

  // **************************************************
  // read back
  // **************************************************

  always_comb begin
    rd_word = '0;
    case (reg_i.addr)
      REG_CTRL: rd_word = ctrl_q.raw;
      REG_IN:   rd_word[`GPIO_IN_W-1:0] = in_q;
      REG_EDGE: rd_word[`GPIO_IN_W-1:0] = edge_q;
      REG_MASK: rd_word[`GPIO_IN_W-1:0] = mask_q;
      default:  rd_word = '0;
    endcase
  end

  // reply for both reads and writes
  always_ff @(posedge sys_clk) begin
    if (reg_i.wr_en || reg_i.rd_en) begin
      rdata_q <= reg_i.addr_err ? '0 : rd_word;
      resp_q  <= axil_resp_of(reg_i.addr_err);
    end
  end

  assign reg_i.rdata = rdata_q;
  assign reg_i.resp  = resp_q;

  assign ctrl_o = ctrl_q;
  // any unmasked captured edge
  assign irq_o  = |(edge_q & mask_q);

endmodule

// File: logic/gpio_in_sync.sv
`timescale 1ns/1ps

`include "gpio_cfg.svh"

module gpio_in_sync (
  input  logic                 sys_clk,
  input  logic                 rst_i,
  input  logic [`GPIO_IN_W-1:0] gpio_bd_i,
  output logic [`GPIO_IN_W-1:0] in_sync_o,
  output logic [`GPIO_IN_W-1:0] in_rise_o
);

  localparam int LAST = `GPIO_SYNC_STAGES - 1;

  // flop chain, stage 0 sees the raw pins
  logic [`GPIO_SYNC_STAGES-1:0][`GPIO_IN_W-1:0] sync_q;
  logic [`GPIO_IN_W-1:0]                        prev_q;
  logic [`GPIO_IN_W-1:0]                        rise_q;

  // **************************************************
  // synchronizer and edge detect
  // **************************************************

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      sync_q <= '0;
      prev_q <= '0;
      rise_q <= '0;
    end else begin
      sync_q[0] <= gpio_bd_i;
      for (int i = 1; i < `GPIO_SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
      // previous synchronized sample
      prev_q <= sync_q[LAST];
      // high for one cycle per 0 -> 1 change
      rise_q <= sync_q[LAST] & ~prev_q;
    end
  end

  assign in_sync_o = sync_q[LAST];
  assign in_rise_o = rise_q;

endmodule

// File: logic/gpio_axil_slave.sv
`timescale 1ns/1ps

`include "gpio_cfg.svh"

module gpio_axil_slave (
  input  logic                       sys_clk,
  input  logic                       rst_i,

  // write address and data
  input  logic [`GPIO_DATA_W-1:0]    s_awaddr_i,
  input  logic                       s_awvalid_i,
  output logic                       s_awready_o,
  input  logic [`GPIO_DATA_W-1:0]    s_wdata_i,
  input  logic                       s_wvalid_i,
  output logic                       s_wready_o,

  // write response
  output gpio_axil_pkg::axil_resp_e  s_bresp_o,
  output logic                       s_bvalid_o,
  input  logic                       s_bready_i,

  // read address and data
  input  logic [`GPIO_DATA_W-1:0]    s_araddr_i,
  input  logic                       s_arvalid_i,
  output logic                       s_arready_o,
  output logic [`GPIO_DATA_W-1:0]    s_rdata_o,
  output gpio_axil_pkg::axil_resp_e  s_rresp_o,
  output logic                       s_rvalid_o,
  input  logic                       s_rready_i,

  gpio_reg_if.master                 reg_o
);

  import gpio_axil_pkg::*;
  import gpio_map_pkg::*;

  logic                    wr_go;
  logic                    rd_go;
  logic [`GPIO_DATA_W-1:0] req_addr;
  logic                    bvalid_q;
  logic                    rvalid_q;
  logic                    wr_fresh_q;
  logic                    rd_fresh_q;
  axil_resp_e              bresp_q;
  axil_resp_e              rresp_q;
  logic [`GPIO_DATA_W-1:0] rdata_q;

  // **************************************************
  // handshakes
  // **************************************************

  // address and data are taken together, only with no response waiting
  assign wr_go = s_awvalid_i && s_wvalid_i && !bvalid_q;
  // write wins a collision, the read is taken a cycle later
  assign rd_go = s_arvalid_i && !rvalid_q && !wr_go;

  assign s_awready_o = wr_go;
  assign s_wready_o  = wr_go;
  assign s_arready_o = rd_go;

  // **************************************************
  // register strobe
  // **************************************************

  assign req_addr = wr_go ? s_awaddr_i : s_araddr_i;

  assign reg_o.wr_en    = wr_go;
  assign reg_o.rd_en    = rd_go;
  assign reg_o.addr     = reg_addr_e'(req_addr[`GPIO_ADDR_W-1:2]);
  // anything past the last register is out of range
  assign reg_o.addr_err = |req_addr[`GPIO_DATA_W-1:`GPIO_ADDR_W];
  assign reg_o.wdata    = s_wdata_i;

  // **************************************************
  // response channels
  // **************************************************

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      bvalid_q   <= 1'b0;
      rvalid_q   <= 1'b0;
      wr_fresh_q <= 1'b0;
      rd_fresh_q <= 1'b0;
    end else begin
      wr_fresh_q <= wr_go;
      rd_fresh_q <= rd_go;
      if (wr_go) begin
        bvalid_q <= 1'b1;
      end else if (s_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_go) begin
        rvalid_q <= 1'b1;
      end else if (s_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // bank reply is only there for one cycle, keep it while the master stalls
  always_ff @(posedge sys_clk) begin
    if (wr_fresh_q) begin
      bresp_q <= reg_o.resp;
    end
    if (rd_fresh_q) begin
      rdata_q <= reg_o.rdata;
      rresp_q <= reg_o.resp;
    end
  end

  assign s_bvalid_o = bvalid_q;
  assign s_bresp_o  = wr_fresh_q ? reg_o.resp : bresp_q;
  assign s_rvalid_o = rvalid_q;
  assign s_rdata_o  = rd_fresh_q ? reg_o.rdata : rdata_q;
  assign s_rresp_o  = rd_fresh_q ? reg_o.resp : rresp_q;

endmodule

// File: logic/gpio_reg_if.sv
`timescale 1ns/1ps

`include "gpio_cfg.svh"

// register access path from the bus stage to the register stage
interface gpio_reg_if;

  import gpio_axil_pkg::*;
  import gpio_map_pkg::*;

  // request, one cycle wide
  logic                    wr_en;
  logic                    rd_en;
  reg_addr_e               addr;
  logic                    addr_err;
  logic [`GPIO_DATA_W-1:0] wdata;

  // reply, valid the cycle after the strobe
  logic [`GPIO_DATA_W-1:0] rdata;
  axil_resp_e              resp;

  modport master (
    output wr_en, rd_en, addr, addr_err, wdata,
    input  rdata, resp
  );

  modport slave (
    input  wr_en, rd_en, addr, addr_err, wdata,
    output rdata, resp
  );

endinterface

// File: logic/gpio_map_pkg.sv
// **************************************************
// register map types
// **************************************************

package gpio_map_pkg;

  `include "gpio_cfg.svh"

  // word index of each register, taken from the byte offsets
  typedef enum logic [1:0] {
    REG_CTRL = 2'(`GPIO_OFS_CTRL >> 2),
    REG_IN   = 2'(`GPIO_OFS_IN >> 2),
    REG_EDGE = 2'(`GPIO_OFS_EDGE >> 2),
    REG_MASK = 2'(`GPIO_OFS_MASK >> 2)
  } reg_addr_e;

  // control word layout, lsb first in the list below
  // 0 txnrx, 1 enable, 2 sync, 3 en_agc, 4 resetb, 11:8 leds
  typedef struct packed {
    logic [19:0]            rsvd_hi;
    logic [`GPIO_LED_W-1:0] board_led;
    logic [2:0]             rsvd_lo;
    logic                   radio_resetb;
    logic                   radio_en_agc;
    logic                   radio_sync;
    logic                   radio_enable;
    logic                   radio_txnrx;
  } gpio_ctrl_fields_t;

  // raw view for the bus, field view for the pins
  typedef union packed {
    logic [`GPIO_DATA_W-1:0] raw;
    gpio_ctrl_fields_t       fields;
  } gpio_ctrl_u;

  // writable bits of ctrl
  localparam logic [`GPIO_DATA_W-1:0] GPIO_CTRL_MASK = 32'h0000_0F1F;

endpackage

// File: logic/gpio_axil_pkg.sv
// **************************************************
// axi4-lite bus side types
// **************************************************

package gpio_axil_pkg;

  // response codes used on bresp and rresp
  // exokay and decerr are never generated here
  typedef enum logic [1:0] {
    AXIL_OKAY   = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_e;

  // helper for the response mux in the register stage
  function automatic axil_resp_e axil_resp_of(input logic err);
    axil_resp_e resp;
    resp = err ? AXIL_SLVERR : AXIL_OKAY;
    return resp;
  endfunction

endpackage

// File: include/gpio_cfg.svh
`ifndef GPIO_CFG_SVH
`define GPIO_CFG_SVH

// **************************************************
// bus geometry
// **************************************************

`define GPIO_DATA_W 32
// byte address bits decoded inside the block
`define GPIO_ADDR_W 4

// board side
`define GPIO_IN_W 8
`define GPIO_LED_W 4
`define GPIO_SYNC_STAGES 2

// register byte offsets
`define GPIO_OFS_CTRL 4'h0
`define GPIO_OFS_IN 4'h4
`define GPIO_OFS_EDGE 4'h8
`define GPIO_OFS_MASK 4'hC

`endif
